//--- src/mat_pkg.sv
package mat_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Matrix shape
	////////////////////////////////////////////////////////////////////////////

	// Order of the square matrix
	localparam int N = 5;

	// Element width, arithmetic wraps at this size
	localparam int ELEM_W = 32;

	////////////////////////////////////////////////////////////////////////////
	// Data types
	////////////////////////////////////////////////////////////////////////////

	// One matrix element, unsigned and wrapping
	typedef logic [ELEM_W-1:0] elem_t;

	// Augmented row [A | I]
	// Words 0..N-1 hold the matrix half, N..2N-1 the inverse half
	typedef elem_t [2*N-1:0] row_t;

	// Row or column index
	typedef logic [$clog2(N)-1:0] col_t;

endpackage

//--- src/seq_pkg.sv
package seq_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Pivot sequencing
	////////////////////////////////////////////////////////////////////////////

	// One pivot step per matrix row
	localparam int STEPS = mat_pkg::N;

	// Step counter, holds 0..STEPS
	typedef logic [$clog2(STEPS+1)-1:0] step_t;

	// Edges from the start sample to the edge that raises done
	localparam int DONE_LATENCY = STEPS + 1;

	////////////////////////////////////////////////////////////////////////////
	// Load and read address map
	////////////////////////////////////////////////////////////////////////////

	localparam int ADDR_W = 5;

	// R entries, row major from address 0
	localparam int INV_WORDS = mat_pkg::N * mat_pkg::N;

	// Diagonal d_0..d_4 directly after R
	localparam int DIAG_BASE = INV_WORDS;

endpackage

//--- src/elim_bus_if.sv
`timescale 1ns/1ns

// Link between the sequencer, one row eliminator and the reader
interface elim_bus_if;

	// Entry load into the matrix half
	logic load_en;
	mat_pkg::col_t load_col;
	mat_pkg::elem_t load_data;

	// Run control
	logic init;
	logic step;
	mat_pkg::col_t pivot_col;
	mat_pkg::row_t pivot_row;

	// Current augmented row of this eliminator
	mat_pkg::row_t cur_row;

	modport seq (
		output load_en,
		output load_col,
		output load_data,
		output init,
		output step,
		output pivot_col,
		output pivot_row,
		input  cur_row
	);

	modport row (
		input  load_en,
		input  load_col,
		input  load_data,
		input  init,
		input  step,
		input  pivot_col,
		input  pivot_row,
		output cur_row
	);

	modport reader (
		input  cur_row
	);

endinterface

//--- src/elim_sequencer.sv
`timescale 1ns/1ns

module elim_sequencer (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        load,
	input  logic [seq_pkg::ADDR_W-1:0]  load_addr,
	input  mat_pkg::elem_t              load_data,
	input  logic                        start,
	output logic                        busy,
	output logic                        done,
	elim_bus_if.seq                     bus [mat_pkg::N]
);

	seq_pkg::step_t cnt;
	logic go;
	logic last;
	logic step_now;

	mat_pkg::col_t ld_row;
	mat_pkg::col_t ld_col;
	logic ld_hit;

	mat_pkg::row_t rows [mat_pkg::N];
	mat_pkg::row_t pivot;

	////////////////////////////////////////////////////////////////////////////
	// Run control
	////////////////////////////////////////////////////////////////////////////

	// Start only counts when idle
	assign go = start && !busy;
	assign last = busy && (cnt == seq_pkg::step_t'(seq_pkg::DONE_LATENCY - 1));
	assign step_now = busy && (cnt < seq_pkg::STEPS);

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			busy <= 1'b0;
			done <= 1'b0;
			cnt <= '0;
		end
		else
		begin
			done <= last;
			if (go)
			begin
				busy <= 1'b1;
				cnt <= '0;
			end
			else if (last)
				busy <= 1'b0;
			else if (busy)
				cnt <= cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Load address decode
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		ld_row = '0;
		ld_col = '0;
		ld_hit = 1'b0;
		for (int i = 0; i < mat_pkg::N; i++)
		begin
			for (int j = 0; j < mat_pkg::N; j++)
			begin
				if (load_addr == seq_pkg::ADDR_W'(i * mat_pkg::N + j))
				begin
					ld_row = mat_pkg::col_t'(i);
					ld_col = mat_pkg::col_t'(j);
					ld_hit = 1'b1;
				end
			end
		end
	end

	// Pivot row k during step k
	assign pivot = (cnt < seq_pkg::STEPS) ? rows[cnt] : '0;

	for (genvar i = 0; i < mat_pkg::N; i++)
	begin : g_bus
		assign rows[i] = bus[i].cur_row;
		assign bus[i].load_en = load && !busy && ld_hit && (ld_row == mat_pkg::col_t'(i));
		assign bus[i].load_col = ld_col;
		assign bus[i].load_data = load_data;
		assign bus[i].init = go;
		assign bus[i].step = step_now;
		assign bus[i].pivot_col = mat_pkg::col_t'(cnt);
		assign bus[i].pivot_row = pivot;
	end

endmodule

//--- src/row_eliminator.sv
`timescale 1ns/1ns

module row_eliminator #(
	parameter int ROW = 0
) (
	input  logic     clk,
	input  logic     reset,
	elim_bus_if.row  bus
);

	mat_pkg::row_t row_q;
	mat_pkg::row_t row_upd;

	// Pivot entry and this row's entry in the pivot column
	mat_pkg::elem_t p;
	mat_pkg::elem_t f;
	logic own_pivot;

	assign p = bus.pivot_row[bus.pivot_col];
	assign f = row_q[bus.pivot_col];
	assign own_pivot = (bus.pivot_col == mat_pkg::col_t'(ROW));

	////////////////////////////////////////////////////////////////////////////
	// Fraction-free update, wraps at the element width
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		for (int j = 0; j < 2 * mat_pkg::N; j++)
		begin
			row_upd[j] = p * row_q[j] - f * bus.pivot_row[j];
		end
	end

	always_ff @(posedge clk)
	begin
		if (!reset)
			row_q <= '0;
		else if (bus.step)
		begin
			// Pivot row itself stays put
			if (!own_pivot)
				row_q <= row_upd;
		end
		else
		begin
			if (bus.load_en)
				row_q[bus.load_col] <= bus.load_data;
			// Unit vector in the inverse half
			if (bus.init)
			begin
				for (int j = 0; j < mat_pkg::N; j++)
				begin
					row_q[mat_pkg::N + j] <= (j == ROW) ? mat_pkg::elem_t'(1) : '0;
				end
			end
		end
	end

	assign bus.cur_row = row_q;

endmodule

//--- src/result_reader.sv
`timescale 1ns/1ns

module result_reader (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        done,
	input  logic [seq_pkg::ADDR_W-1:0]  rd_addr,
	output mat_pkg::elem_t              rd_data,
	output logic                        singular,
	elim_bus_if.reader                  bus [mat_pkg::N]
);

	mat_pkg::row_t rows [mat_pkg::N];
	mat_pkg::elem_t rd_next;
	logic [mat_pkg::N-1:0] diag_zero;
	logic singular_q;

	for (genvar i = 0; i < mat_pkg::N; i++)
	begin : g_rows
		assign rows[i] = bus[i].cur_row;
		assign diag_zero[i] = (rows[i][i] == '0);
	end

	////////////////////////////////////////////////////////////////////////////
	// Read mux, R first and then the diagonal
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		rd_next = '0;
		if (rd_addr < seq_pkg::INV_WORDS)
		begin
			for (int i = 0; i < mat_pkg::N; i++)
			begin
				for (int j = 0; j < mat_pkg::N; j++)
				begin
					if (rd_addr == seq_pkg::ADDR_W'(i * mat_pkg::N + j))
						rd_next = rows[i][mat_pkg::N + j];
				end
			end
		end
		else
		begin
			for (int i = 0; i < mat_pkg::N; i++)
			begin
				if (rd_addr == seq_pkg::ADDR_W'(seq_pkg::DIAG_BASE + i))
					rd_next = rows[i][i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			rd_data <= '0;
			singular_q <= 1'b0;
		end
		else
		begin
			rd_data <= rd_next;
			if (done)
				singular_q <= |diag_zero;
		end
	end

	// Live during the done cycle, held afterwards
	assign singular = done ? |diag_zero : singular_q;

endmodule

//--- src/gj_inverse_top.sv
`timescale 1ns/1ns

module gj_inverse_top (
	input  logic                        clk,
	input  logic                        reset,

	// Entry load
	input  logic                        load,
	input  logic [seq_pkg::ADDR_W-1:0]  load_addr,
	input  mat_pkg::elem_t              load_data,

	// Run control
	input  logic                        start,
	output logic                        busy,
	output logic                        done,
	output logic                        singular,

	// Result read port
	input  logic [seq_pkg::ADDR_W-1:0]  rd_addr,
	output mat_pkg::elem_t              rd_data
);

	////////////////////////////////////////////////////////////////////////////
	// One bus per matrix row
	////////////////////////////////////////////////////////////////////////////

	elim_bus_if bus [mat_pkg::N] ();

	elim_sequencer i_elim_sequencer (
		.clk       (clk),
		.reset     (reset),
		.load      (load),
		.load_addr (load_addr),
		.load_data (load_data),
		.start     (start),
		.busy      (busy),
		.done      (done),
		.bus       (bus)
	);

	////////////////////////////////////////////////////////////////////////////
	// Row eliminators
	////////////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < mat_pkg::N; i++)
	begin : g_row
		row_eliminator #(
			.ROW (i)
		) i_row_eliminator (
			.clk   (clk),
			.reset (reset),
			.bus   (bus[i])
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// Read back
	////////////////////////////////////////////////////////////////////////////

	result_reader i_result_reader (
		.clk      (clk),
		.reset    (reset),
		.done     (done),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.singular (singular),
		.bus      (bus)
	);

endmodule

//--- test/gj_model.svh
`ifndef GJ_MODEL_SVH
`define GJ_MODEL_SVH

typedef mat_pkg::elem_t mat_t [mat_pkg::N][mat_pkg::N];
typedef mat_pkg::elem_t vec_t [mat_pkg::N];

// Fraction-free Gauss-Jordan on [A | I], every product wraps at 32 bits
function automatic void model_inverse(input mat_t a, output mat_t r, output vec_t d);
	mat_pkg::elem_t m [mat_pkg::N][2*mat_pkg::N];
	mat_pkg::elem_t p;
	mat_pkg::elem_t f;
	for (int i = 0; i < mat_pkg::N; i++)
	begin
		for (int j = 0; j < mat_pkg::N; j++)
		begin
			m[i][j] = a[i][j];
			m[i][mat_pkg::N + j] = (i == j) ? mat_pkg::elem_t'(1) : '0;
		end
	end
	for (int k = 0; k < mat_pkg::N; k++)
	begin
		p = m[k][k];
		for (int i = 0; i < mat_pkg::N; i++)
		begin
			if (i != k)
			begin
				// Factor taken before the row changes
				f = m[i][k];
				for (int j = 0; j < 2 * mat_pkg::N; j++)
					m[i][j] = p * m[i][j] - f * m[k][j];
			end
		end
	end
	for (int i = 0; i < mat_pkg::N; i++)
	begin
		d[i] = m[i][i];
		for (int j = 0; j < mat_pkg::N; j++)
			r[i][j] = m[i][mat_pkg::N + j];
	end
endfunction

// Entries where R*A differs from diag(d)
function automatic int identity_mismatches(input mat_t a, input mat_t r, input vec_t d);
	int bad;
	mat_pkg::elem_t acc;
	mat_pkg::elem_t want;
	bad = 0;
	for (int i = 0; i < mat_pkg::N; i++)
	begin
		for (int j = 0; j < mat_pkg::N; j++)
		begin
			acc = '0;
			for (int k = 0; k < mat_pkg::N; k++)
				acc = acc + r[i][k] * a[k][j];
			want = (i == j) ? d[i] : '0;
			if (acc !== want)
				bad++;
		end
	end
	return bad;
endfunction

function automatic logic expect_singular(input vec_t d);
	logic zero_seen;
	zero_seen = 1'b0;
	for (int i = 0; i < mat_pkg::N; i++)
	begin
		if (d[i] == '0)
			zero_seen = 1'b1;
	end
	return zero_seen;
endfunction

`endif

//--- test/gj_inverse_tb.sv
`timescale 1ns/1ns

module gj_inverse_tb;

	`include "gj_model.svh"

	localparam int HALF_PERIOD = 4;
	localparam int RESET_CYCLES = 3;
	localparam int RANDOM_RUNS = 20;
	// Cycles to load, run and read back one matrix plus margin
	localparam int RUN_CYCLES = 70;
	localparam int TIMEOUT = 2 * ((RANDOM_RUNS + 3) * RUN_CYCLES + RESET_CYCLES);
	localparam logic [31:0] SEED = 32'd90769;

	logic clk;
	logic reset;
	logic load;
	logic [seq_pkg::ADDR_W-1:0] load_addr;
	mat_pkg::elem_t load_data;
	logic start;
	logic busy;
	logic done;
	logic singular;
	logic [seq_pkg::ADDR_W-1:0] rd_addr;
	mat_pkg::elem_t rd_data;

	int checks = 0;
	int errors = 0;
	int cycles = 0;
	int edges;
	logic [31:0] lcg_state;
	mat_t a_cur;
	mat_t r_exp;
	mat_t r_dut;
	vec_t d_exp;
	vec_t d_dut;

	gj_inverse_top i_gj_inverse_top (
		.clk       (clk),
		.reset     (reset),
		.load      (load),
		.load_addr (load_addr),
		.load_data (load_data),
		.start     (start),
		.busy      (busy),
		.done      (done),
		.singular  (singular),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data)
	);

	initial clk = 1'b0;
	always #HALF_PERIOD clk = ~clk;

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > TIMEOUT)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
			$display("TESTS FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Protocol checks on every edge
	////////////////////////////////////////////////////////////////////////////

	done_one_cycle: assert property (@(posedge clk) disable iff (!reset) done |=> !done)
	else
	begin
		errors++;
		$display("** Error at %0t ns: done expected 0, got 1", $time);
	end

	done_idle: assert property (@(posedge clk) disable iff (!reset) done |-> !busy)
	else
	begin
		errors++;
		$display("** Error at %0t ns: busy expected 0, got 1", $time);
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_value(input string name, input mat_pkg::elem_t exp,
		input mat_pkg::elem_t got);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
		end
	endtask

	task automatic load_matrix(input mat_t a);
		for (int i = 0; i < mat_pkg::N; i++)
		begin
			for (int j = 0; j < mat_pkg::N; j++)
			begin
				load = 1'b1;
				load_addr = seq_pkg::ADDR_W'(i * mat_pkg::N + j);
				load_data = a[i][j];
				@(negedge clk);
			end
		end
		load = 1'b0;
	endtask

	task automatic read_word(input int addr, output mat_pkg::elem_t data);
		rd_addr = seq_pkg::ADDR_W'(addr);
		@(negedge clk);
		data = rd_data;
	endtask

	// Start, then count edges until done; noise adds loads and starts while busy
	task automatic run_matrix(input bit noise, input logic exp_singular);
		logic [31:0] rnd;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		edges = 0;
		while (!done)
		begin
			check_value("busy", 32'd1, 32'(busy));
			if (noise)
			begin
				rnd = lcg_next();
				load = 1'b1;
				load_addr = rnd[20:16];
				load_data = lcg_next();
				start = 1'b1;
			end
			@(negedge clk);
			edges++;
		end
		load = 1'b0;
		start = 1'b0;
		check_value("done latency", 32'(seq_pkg::DONE_LATENCY), 32'(edges));
		check_value("singular", 32'(exp_singular), 32'(singular));
		@(negedge clk);
		check_value("singular", 32'(exp_singular), 32'(singular));
	endtask

	task automatic run_and_check(input mat_t a, input bit noise);
		mat_pkg::elem_t word;
		a_cur = a;
		model_inverse(a, r_exp, d_exp);
		load_matrix(a);
		run_matrix(noise, expect_singular(d_exp));
		for (int i = 0; i < mat_pkg::N; i++)
		begin
			for (int j = 0; j < mat_pkg::N; j++)
			begin
				read_word(i * mat_pkg::N + j, r_dut[i][j]);
				check_value($sformatf("R[%0d][%0d]", i, j), r_exp[i][j], r_dut[i][j]);
			end
		end
		for (int i = 0; i < mat_pkg::N; i++)
		begin
			read_word(seq_pkg::DIAG_BASE + i, d_dut[i]);
			check_value($sformatf("d[%0d]", i), d_exp[i], d_dut[i]);
		end
		for (int addr = 30; addr < 32; addr++)
		begin
			read_word(addr, word);
			check_value($sformatf("rd_data at %0d", addr), '0, word);
		end
		// R*A against diag(d) from A and the values read back
		checks++;
		assert (identity_mismatches(a_cur, r_dut, d_dut) == 0)
		else
		begin
			errors++;
			$display("Error at %0t ns: R*A read back from the DUT differs from diag(d)", $time);
		end
	endtask

	initial
	begin
		mat_t diag_a;
		mat_t a;
		int primes [mat_pkg::N];
		primes = '{2, 3, 5, 7, 11};
		lcg_state = SEED;
		reset = 1'b0;
		load = 1'b0;
		load_addr = '0;
		load_data = '0;
		// Start held during reset must not begin a run
		start = 1'b1;
		rd_addr = '0;

		repeat (RESET_CYCLES + 1)
		begin
			@(negedge clk);
			reset = 1'b1;
			if (cycles < RESET_CYCLES)
				reset = 1'b0;
			start = 1'b0;
			check_value("busy", '0, 32'(busy));
			check_value("done", '0, 32'(done));
			check_value("singular", '0, 32'(singular));
			check_value("rd_data", '0, rd_data);
		end

		for (int i = 0; i < mat_pkg::N; i++)
		begin
			for (int j = 0; j < mat_pkg::N; j++)
				diag_a[i][j] = (i == j) ? mat_pkg::elem_t'(primes[i]) : '0;
		end
		run_and_check(diag_a, 1'b0);
		for (int i = 0; i < mat_pkg::N; i++)
		begin
			for (int j = 0; j < mat_pkg::N; j++)
			begin
				if (i != j)
					check_value($sformatf("R[%0d][%0d] off diagonal", i, j), '0, r_dut[i][j]);
			end
		end

		// Registered read port holds the old word until the next edge
		rd_addr = '0;
		@(negedge clk);
		rd_addr = seq_pkg::ADDR_W'(seq_pkg::DIAG_BASE);
		#1;
		check_value("rd_data before edge", r_exp[0][0], rd_data);
		@(negedge clk);
		check_value("rd_data after edge", d_exp[0], rd_data);

		// Rows 0 and 1 equal
		for (int i = 0; i < mat_pkg::N; i++)
		begin
			for (int j = 0; j < mat_pkg::N; j++)
				a[i][j] = mat_pkg::elem_t'((lcg_next() >> 16) & 32'hF);
		end
		a[1] = a[0];
		run_and_check(a, 1'b0);
		check_value("singular", 32'd1, 32'(singular));
		run_and_check(diag_a, 1'b1);
		check_value("singular", '0, 32'(singular));

		for (int n = 0; n < RANDOM_RUNS; n++)
		begin
			for (int i = 0; i < mat_pkg::N; i++)
			begin
				for (int j = 0; j < mat_pkg::N; j++)
					a[i][j] = mat_pkg::elem_t'((lcg_next() >> 16) & 32'hF);
			end
			run_and_check(a, n[0]);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- build.f
src/mat_pkg.sv
src/seq_pkg.sv
src/elim_bus_if.sv
src/elim_sequencer.sv
src/row_eliminator.sv
src/result_reader.sv
src/gj_inverse_top.sv
+incdir+test
test/gj_inverse_tb.sv

//--- Makefile
# Verilator build and run of the matrix inverter testbench

VERILATOR ?= verilator
TOP       ?= gj_inverse_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= build.f
VFLAGS    ?= --binary --assert --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard test/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
